//--- lc4_decode.sv
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_decode import lc4_pkg::*; (
   input  logic     gwe,
   input  logic     i_rst,
   input  logic     i_flush,
   input  logic     i_valid,
   input  word_t    i_pc,
   input  insn_u    i_insn,
   input  word_t    i_rs_data,
   input  word_t    i_rt_data,
   output reg_idx_t o_rs_sel,
   output reg_idx_t o_rt_sel,
   output ctrl_t    o_dx,
   output word_t    o_rs_val,
   output word_t    o_rt_val
);

   ctrl_t dx_d;

   assign o_rs_sel = i_insn.rr.rs;
   assign o_rt_sel = i_insn.rr.rt;

   always_comb begin
      dx_d             = '0;
      dx_d.valid       = 1'b1;
      dx_d.pc          = i_pc;
      dx_d.pc_plus_one = i_pc + 1'b1;
      dx_d.insn        = i_insn;
      dx_d.rs          = i_insn.rr.rs;
      dx_d.rt          = i_insn.rr.rt;
      dx_d.rd          = i_insn.rr.rd;
      case (i_insn.rr.opcode)
         `LC4_OP_BR: begin
            dx_d.is_branch = 1'b1;
            dx_d.nzp_mask  = i_insn.ri.rd;
            dx_d.imm       = {{(`LC4_XLEN-9){i_insn.ri.imm9[8]}}, i_insn.ri.imm9};
         end
         `LC4_OP_ARITH, `LC4_OP_LOGIC: begin
            dx_d.rs_re  = 1'b1;
            dx_d.rf_we  = 1'b1;
            dx_d.nzp_we = 1'b1;
            if (i_insn.ri.imm9[5]) begin
               // ADD imm5 or AND imm5
               dx_d.use_imm = 1'b1;
               dx_d.imm     = {{(`LC4_XLEN-5){i_insn.ri.imm9[4]}}, i_insn.ri.imm9[4:0]};
               dx_d.alu_op  = (i_insn.rr.opcode == `LC4_OP_ARITH) ? ALU_ADD : ALU_AND;
            end else begin
               dx_d.rt_re = 1'b1;
               if (i_insn.rr.opcode == `LC4_OP_ARITH) begin
                  case (i_insn.rr.sub)
                     `LC4_SUB_ADD: dx_d.alu_op = ALU_ADD;
                     `LC4_SUB_SUB: dx_d.alu_op = ALU_SUB;
                     default: {dx_d.rs_re, dx_d.rt_re, dx_d.rf_we, dx_d.nzp_we} = '0;
                  endcase
               end else begin
                  case (i_insn.rr.sub)
                     `LC4_SUB_AND: dx_d.alu_op = ALU_AND;
                     `LC4_SUB_OR:  dx_d.alu_op = ALU_OR;
                     `LC4_SUB_XOR: dx_d.alu_op = ALU_XOR;
                     default: {dx_d.rs_re, dx_d.rt_re, dx_d.rf_we, dx_d.nzp_we} = '0;
                  endcase
               end
            end
         end
         `LC4_OP_CONST: begin
            dx_d.rf_we   = 1'b1;
            dx_d.nzp_we  = 1'b1;
            dx_d.use_imm = 1'b1;
            dx_d.alu_op  = ALU_PASS;
            dx_d.imm     = {{(`LC4_XLEN-9){i_insn.ri.imm9[8]}}, i_insn.ri.imm9};
         end
         // Anything else retires as a NOP
         default: ;
      endcase
   end

   always_ff @(posedge gwe) begin
      if (i_rst || i_flush || !i_valid) begin
         o_dx <= '0;
      end else begin
         o_dx <= dx_d;
      end
   end

   always_ff @(posedge gwe) begin
      o_rs_val <= i_rs_data;
      o_rt_val <= i_rt_data;
   end

endmodule

//--- lc4_execute.sv
`timescale 1ns/1ps

module lc4_execute import lc4_pkg::*; (
   input  logic   gwe,
   input  logic   i_rst,
   input  ctrl_t  i_dx,
   input  word_t  i_rs_val,
   input  word_t  i_rt_val,
   input  trace_t i_wb,
   output xw_t    o_xw,
   output logic   o_redirect,
   output word_t  o_target
);

   word_t rs_fwd;
   word_t rt_fwd;
   word_t op_b;
   word_t alu_out;
   nzp_t  nzp_q;
   logic  take;

   // Writeback to execute bypass
   always_comb begin
      rs_fwd = i_rs_val;
      rt_fwd = i_rt_val;
      if (i_wb.rf_we && i_dx.rs_re && (i_wb.rf_wsel == i_dx.rs)) begin
         rs_fwd = i_wb.rf_data;
      end
      if (i_wb.rf_we && i_dx.rt_re && (i_wb.rf_wsel == i_dx.rt)) begin
         rt_fwd = i_wb.rf_data;
      end
   end

   assign op_b = i_dx.use_imm ? i_dx.imm : rt_fwd;

   always_comb begin
      case (i_dx.alu_op)
         ALU_ADD:  alu_out = rs_fwd + op_b;
         ALU_SUB:  alu_out = rs_fwd - op_b;
         ALU_AND:  alu_out = rs_fwd & op_b;
         ALU_OR:   alu_out = rs_fwd | op_b;
         ALU_XOR:  alu_out = rs_fwd ^ op_b;
         ALU_PASS: alu_out = op_b;
         default:  alu_out = '0;
      endcase
   end

   // Condition codes written at the end of the execute cycle
   always_ff @(posedge gwe) begin
      if (i_rst) begin
         nzp_q <= '0;
      end else if (i_dx.valid && i_dx.nzp_we) begin
         nzp_q <= nzp_of(alu_out);
      end
   end

   // Branch resolves against the stored NZP
   assign take       = |(i_dx.nzp_mask & nzp_q);
   assign o_redirect = i_dx.valid && i_dx.is_branch && take;
   assign o_target   = i_dx.pc_plus_one + i_dx.imm;

   assign o_xw = '{ctrl: i_dx, result: alu_out};

endmodule

//--- lc4_macros.svh
`ifndef LC4_MACROS_SVH
`define LC4_MACROS_SVH

// Datapath sizes
`define LC4_XLEN      16
`define LC4_NREGS     8

// First fetch address after reset
`define LC4_RESET_PC  16'h8200

// Major opcodes in insn[15:12]
`define LC4_OP_BR     4'b0000
`define LC4_OP_ARITH  4'b0001
`define LC4_OP_LOGIC  4'b0101
`define LC4_OP_CONST  4'b1001

// Sub-opcodes in insn[5:3] of the register form
`define LC4_SUB_ADD   3'b000
`define LC4_SUB_SUB   3'b010
`define LC4_SUB_AND   3'b000
`define LC4_SUB_OR    3'b010
`define LC4_SUB_XOR   3'b011

`endif

//--- lc4_pipe.f
+incdir+.
lc4_pkg.sv
lc4_regfile.sv
lc4_decode.sv
lc4_execute.sv
lc4_result.sv
lc4_pipe.sv
lc4_pipe_properties.sv
lc4_pipe_tb.sv

//--- lc4_pipe.sv
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_pipe import lc4_pkg::*; (
   input  logic   gwe,
   input  logic   i_rst,
   output word_t  o_imem_addr,
   input  word_t  i_imem_insn,
   output trace_t o_trace
);

   word_t    pc_q;
   logic     fd_valid;
   word_t    fd_pc;
   insn_u    fd_insn;
   reg_idx_t rs_sel;
   reg_idx_t rt_sel;
   word_t    rs_data;
   word_t    rt_data;
   ctrl_t    dx;
   word_t    dx_rs_val;
   word_t    dx_rt_val;
   xw_t      xw;
   logic     redirect;
   word_t    target;
   reg_idx_t wsel;
   word_t    wdata;
   logic     we;
   trace_t   wb;

   // Fetch
   always_ff @(posedge gwe) begin
      if (i_rst) begin
         pc_q <= `LC4_RESET_PC;
      end else if (redirect) begin
         pc_q <= target;
      end else begin
         pc_q <= pc_q + 1'b1;
      end
   end

   assign o_imem_addr = pc_q;

   // Wrong path dropped from fetch-to-decode on redirect
   always_ff @(posedge gwe) begin
      if (i_rst || redirect) begin
         fd_valid <= 1'b0;
      end else begin
         fd_valid <= 1'b1;
      end
   end

   always_ff @(posedge gwe) begin
      fd_pc   <= pc_q;
      fd_insn <= i_imem_insn;
   end

   lc4_regfile lc4_regfile_inst (
      .gwe       (gwe),
      .i_rst     (i_rst),
      .i_rs_sel  (rs_sel),
      .i_rt_sel  (rt_sel),
      .o_rs_data (rs_data),
      .o_rt_data (rt_data),
      .i_wsel    (wsel),
      .i_wdata   (wdata),
      .i_we      (we)
   );

   lc4_decode lc4_decode_inst (
      .gwe       (gwe),
      .i_rst     (i_rst),
      .i_flush   (redirect),
      .i_valid   (fd_valid),
      .i_pc      (fd_pc),
      .i_insn    (fd_insn),
      .i_rs_data (rs_data),
      .i_rt_data (rt_data),
      .o_rs_sel  (rs_sel),
      .o_rt_sel  (rt_sel),
      .o_dx      (dx),
      .o_rs_val  (dx_rs_val),
      .o_rt_val  (dx_rt_val)
   );

   lc4_execute lc4_execute_inst (
      .gwe        (gwe),
      .i_rst      (i_rst),
      .i_dx       (dx),
      .i_rs_val   (dx_rs_val),
      .i_rt_val   (dx_rt_val),
      .i_wb       (wb),
      .o_xw       (xw),
      .o_redirect (redirect),
      .o_target   (target)
   );

   lc4_result lc4_result_inst (
      .gwe     (gwe),
      .i_rst   (i_rst),
      .i_xw    (xw),
      .o_wsel  (wsel),
      .o_wdata (wdata),
      .o_we    (we),
      .o_wb    (wb),
      .o_trace (o_trace)
   );

endmodule

//--- lc4_pipe_properties.sv
`timescale 1ns/1ps

module lc4_pipe_properties import lc4_pkg::*; (
   input logic   gwe,
   input logic   i_rst,
   input ctrl_t  i_dx,
   input trace_t i_trace,
   input word_t  i_imem_addr,
   input logic   i_redirect,
   input word_t  i_target
);

   int assert_fails = 0;

   // A bubble leaving decode never carries a register write
   we_needs_valid: assert property (@(posedge gwe) disable iff (i_rst)
      i_dx.rf_we |-> i_dx.valid)
      else begin
         assert_fails++;
         $error("rf_we set on an invalid decode-to-execute entry");
      end

   // Reset empties writeback on the next edge
   quiet_in_reset: assert property (@(posedge gwe) i_rst |=> !i_trace.valid)
      else begin
         assert_fails++;
         $error("valid trace entry while reset is high");
      end

   redirect_target: assert property (@(posedge gwe) disable iff (i_rst)
      i_redirect |=> (i_imem_addr == $past(i_target)))
      else begin
         assert_fails++;
         $error("fetch address does not follow the branch target");
      end

endmodule

bind lc4_pipe lc4_pipe_properties lc4_pipe_properties_inst (
   .gwe         (gwe),
   .i_rst       (i_rst),
   .i_dx        (dx),
   .i_trace     (o_trace),
   .i_imem_addr (o_imem_addr),
   .i_redirect  (redirect),
   .i_target    (target)
);

//--- lc4_pipe_tb.sv
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_pipe_tb import lc4_pkg::*; ();

   localparam int N_TESTS    = 6;
   localparam int RST_CYCLES = 16;
   localparam int RUN_CYCLES = 40;
   localparam int TAIL       = 10;
   localparam int PROG_LEN   = 64;

   logic   gwe;
   logic   i_rst;
   word_t  o_imem_addr;
   word_t  i_imem_insn;
   trace_t o_trace;

   word_t  prog [PROG_LEN];
   int     prog_len;
   word_t  imem_off;
   trace_t exp_q [$];
   string  test_name;
   int     errors;
   int     checks;
   int     afails;

   lc4_pipe lc4_pipe_inst (
      .gwe         (gwe),
      .i_rst       (i_rst),
      .o_imem_addr (o_imem_addr),
      .i_imem_insn (i_imem_insn),
      .o_trace     (o_trace)
   );

   initial begin
      gwe = 1'b0;
      forever #50 gwe = ~gwe;
   end

   // Instruction memory returns NOP outside the program
   assign imem_off    = o_imem_addr - `LC4_RESET_PC;
   assign i_imem_insn = (imem_off < 16'(PROG_LEN)) ? prog[imem_off[5:0]] : '0;

   initial begin
      #(N_TESTS * (RST_CYCLES + RUN_CYCLES + TAIL) * 100);
      $display("Watchdog expired before the tests finished");
      $display("TEST FAILED");
      $finish;
   end

   task automatic compare_word(input string what, input word_t exp, input word_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic compare_reg(input string what, input reg_idx_t exp, input reg_idx_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAIL %s %s: expected r%0d, actual r%0d", test_name, what, exp, act);
      end
   endtask

   task automatic compare_nzp(input string what, input nzp_t exp, input nzp_t act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAIL %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic compare_flag(input string what, input logic exp, input logic act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("FAIL %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   function automatic word_t rr_insn(input logic [3:0] op, input int rd, input int rs,
                                     input logic [2:0] sub, input int rt);
      return {op, rd[2:0], rs[2:0], sub, rt[2:0]};
   endfunction

   function automatic word_t imm5_insn(input logic [3:0] op, input int rd, input int rs,
                                       input int imm);
      return {op, rd[2:0], rs[2:0], 1'b1, imm[4:0]};
   endfunction

   function automatic word_t const_insn(input int rd, input int imm);
      return {`LC4_OP_CONST, rd[2:0], imm[8:0]};
   endfunction

   function automatic word_t br_insn(input int mask, input int imm);
      return {`LC4_OP_BR, mask[2:0], imm[8:0]};
   endfunction

   task automatic clear_prog();
      for (int i = 0; i < PROG_LEN; i++) begin
         prog[i] = '0;
      end
      prog_len = 0;
   endtask

   task automatic append_insn(input word_t w);
      prog[prog_len] = w;
      prog_len++;
   endtask

   // In-order model producing one expected trace entry per retired instruction
   task automatic run_model();
      word_t  regs [`LC4_NREGS];
      nzp_t   nzp;
      word_t  pc;
      word_t  off;
      word_t  w;
      word_t  a;
      word_t  b;
      word_t  r;
      logic   wr;
      trace_t t;
      int     steps;
      for (int i = 0; i < `LC4_NREGS; i++) begin
         regs[i] = '0;
      end
      nzp   = 3'b000;
      pc    = `LC4_RESET_PC;
      off   = '0;
      steps = 0;
      exp_q.delete();
      while (off < 16'(prog_len) && steps < 200) begin
         w       = prog[off[5:0]];
         a       = regs[w[8:6]];
         b       = w[5] ? {{(`LC4_XLEN-5){w[4]}}, w[4:0]} : regs[w[2:0]];
         r       = '0;
         wr      = 1'b1;
         t       = '0;
         t.valid = 1'b1;
         t.pc    = pc;
         t.insn  = w;
         pc      = pc + 16'd1;
         case (w[15:12])
            `LC4_OP_ARITH: begin
               if (w[5] || w[5:3] == `LC4_SUB_ADD) begin
                  r = a + b;
               end else if (w[5:3] == `LC4_SUB_SUB) begin
                  r = a - b;
               end else begin
                  wr = 1'b0;
               end
            end
            `LC4_OP_LOGIC: begin
               if (w[5] || w[5:3] == `LC4_SUB_AND) begin
                  r = a & b;
               end else if (w[5:3] == `LC4_SUB_OR) begin
                  r = a | b;
               end else if (w[5:3] == `LC4_SUB_XOR) begin
                  r = a ^ b;
               end else begin
                  wr = 1'b0;
               end
            end
            `LC4_OP_CONST: r = {{(`LC4_XLEN-9){w[8]}}, w[8:0]};
            `LC4_OP_BR: begin
               wr = 1'b0;
               if ((w[11:9] & nzp) != 3'b000) begin
                  pc = pc + {{(`LC4_XLEN-9){w[8]}}, w[8:0]};
               end
            end
            default: wr = 1'b0;
         endcase
         if (wr) begin
            regs[w[11:9]] = r;
            nzp = (r == '0) ? 3'b010 : (r[`LC4_XLEN-1] ? 3'b100 : 3'b001);
            t.rf_we    = 1'b1;
            t.rf_wsel  = w[11:9];
            t.rf_data  = r;
            t.nzp_we   = 1'b1;
            t.nzp_bits = nzp;
         end
         exp_q.push_back(t);
         off = pc - `LC4_RESET_PC;
         steps++;
      end
   endtask

   // Valid entries are compared in order at the falling edge
   task automatic watch_trace();
      trace_t e;
      forever begin
         @(negedge gwe);
         if (!i_rst && o_trace.valid && exp_q.size() > 0) begin
            e = exp_q.pop_front();
            compare_word("pc", e.pc, o_trace.pc);
            compare_word("insn", e.insn, o_trace.insn);
            compare_flag("rf_we", e.rf_we, o_trace.rf_we);
            compare_flag("nzp_we", e.nzp_we, o_trace.nzp_we);
            if (e.rf_we) begin
               compare_reg("rf_wsel", e.rf_wsel, o_trace.rf_wsel);
               compare_word("rf_data", e.rf_data, o_trace.rf_data);
            end
            if (e.nzp_we) begin
               compare_nzp("nzp_bits", e.nzp_bits, o_trace.nzp_bits);
            end
         end
      end
   endtask

   // Entered right after a rising edge
   task automatic apply_reset();
      i_rst <= 1'b1;
      for (int i = 0; i < RST_CYCLES; i++) begin
         @(negedge gwe);
         if (i > 0) begin
            compare_word("imem_addr in reset", `LC4_RESET_PC, o_imem_addr);
            if (o_trace.valid !== 1'b0) begin
               errors++;
               $display("%s: trace entry marked valid while reset is high", test_name);
            end
         end
         @(posedge gwe);
      end
   endtask

   task automatic run_program(input string name);
      int cycles;
      test_name = name;
      apply_reset();
      run_model();
      i_rst <= 1'b0;
      cycles = 0;
      while (exp_q.size() > 0 && cycles < RUN_CYCLES + TAIL) begin
         @(posedge gwe);
         cycles++;
      end
      if (exp_q.size() > 0) begin
         errors++;
         $display("%s: %0d expected entries never retired", test_name, exp_q.size());
         exp_q.delete();
      end
   endtask

   task automatic test_reset();
      clear_prog();
      append_insn(const_insn(0, 5));
      append_insn(const_insn(1, -3));
      append_insn(imm5_insn(`LC4_OP_ARITH, 2, 1, 4));
      run_program("reset");
   endtask

   task automatic test_bypass();
      clear_prog();
      append_insn(const_insn(1, 7));
      append_insn(const_insn(2, 3));
      // r2 from the writeback bypass, r1 through the register file
      append_insn(rr_insn(`LC4_OP_ARITH, 3, 1, `LC4_SUB_ADD, 2));
      append_insn(rr_insn(`LC4_OP_ARITH, 4, 3, `LC4_SUB_SUB, 2));
      append_insn(rr_insn(`LC4_OP_ARITH, 4, 4, `LC4_SUB_ADD, 3));
      append_insn(rr_insn(`LC4_OP_ARITH, 5, 4, `LC4_SUB_SUB, 4));
      append_insn(imm5_insn(`LC4_OP_ARITH, 6, 5, -1));
      append_insn(rr_insn(`LC4_OP_ARITH, 7, 6, `LC4_SUB_ADD, 3));
      run_program("bypass");
   endtask

   task automatic test_logic();
      clear_prog();
      append_insn(const_insn(1, 165));
      append_insn(const_insn(2, -100));
      append_insn(rr_insn(`LC4_OP_LOGIC, 3, 1, `LC4_SUB_AND, 2));
      append_insn(rr_insn(`LC4_OP_LOGIC, 4, 1, `LC4_SUB_OR, 2));
      append_insn(rr_insn(`LC4_OP_LOGIC, 5, 1, `LC4_SUB_XOR, 2));
      append_insn(imm5_insn(`LC4_OP_LOGIC, 6, 2, -2));
      append_insn(imm5_insn(`LC4_OP_ARITH, 7, 1, 15));
      append_insn(imm5_insn(`LC4_OP_ARITH, 0, 1, -16));
      append_insn(const_insn(0, -256));
      append_insn(const_insn(1, 255));
      run_program("logic");
   endtask

   task automatic test_nzp();
      clear_prog();
      append_insn(const_insn(0, 0));
      append_insn(const_insn(1, -1));
      append_insn(imm5_insn(`LC4_OP_ARITH, 2, 1, 1));
      append_insn(rr_insn(`LC4_OP_ARITH, 3, 0, `LC4_SUB_SUB, 1));
      append_insn(rr_insn(`LC4_OP_ARITH, 4, 1, `LC4_SUB_ADD, 1));
      append_insn(const_insn(5, 255));
      append_insn(rr_insn(`LC4_OP_LOGIC, 6, 5, `LC4_SUB_XOR, 5));
      append_insn(rr_insn(`LC4_OP_LOGIC, 7, 5, `LC4_SUB_OR, 1));
      // Dropped sub-opcode and dropped opcode both retire as NOP
      append_insn(rr_insn(`LC4_OP_ARITH, 2, 1, 3'b001, 1));
      append_insn(16'hF123);
      run_program("nzp");
   endtask

   task automatic test_branch();
      clear_prog();
      append_insn(const_insn(1, 1));
      append_insn(br_insn(3'b001, 2));
      append_insn(const_insn(2, 9));
      append_insn(const_insn(3, 9));
      append_insn(br_insn(3'b100, 1));
      append_insn(rr_insn(`LC4_OP_ARITH, 4, 1, `LC4_SUB_ADD, 1));
      append_insn(const_insn(0, 0));
      append_insn(br_insn(3'b110, 1));
      append_insn(const_insn(5, -5));
      append_insn(br_insn(3'b111, 0));
      append_insn(rr_insn(`LC4_OP_ARITH, 6, 4, `LC4_SUB_SUB, 1));
      // Count-down loop through a backward branch
      append_insn(const_insn(7, 2));
      append_insn(imm5_insn(`LC4_OP_ARITH, 7, 7, -1));
      append_insn(br_insn(3'b001, -2));
      append_insn(rr_insn(`LC4_OP_ARITH, 3, 7, `LC4_SUB_ADD, 6));
      run_program("branch");
   endtask

   task automatic test_random();
      int kind;
      int rd;
      int rs;
      int rt;
      int sel;
      clear_prog();
      for (int i = 0; i < 30; i++) begin
         kind = $urandom_range(5, 0);
         rd   = $urandom_range(7, 0);
         rs   = $urandom_range(7, 0);
         rt   = $urandom_range(7, 0);
         sel  = $urandom_range(2, 0);
         case (kind)
            0: append_insn(const_insn(rd, $urandom_range(511, 0)));
            1: append_insn(rr_insn(`LC4_OP_ARITH, rd, rs,
                                   (sel == 0) ? `LC4_SUB_SUB : `LC4_SUB_ADD, rt));
            2: append_insn(rr_insn(`LC4_OP_LOGIC, rd, rs, (sel == 0) ? `LC4_SUB_AND :
                                   ((sel == 1) ? `LC4_SUB_OR : `LC4_SUB_XOR), rt));
            3: append_insn(imm5_insn(`LC4_OP_ARITH, rd, rs, $urandom_range(31, 0)));
            4: append_insn(imm5_insn(`LC4_OP_LOGIC, rd, rs, $urandom_range(31, 0)));
            // Forward only, so the program always ends
            default: append_insn(br_insn($urandom_range(7, 0), $urandom_range(2, 1)));
         endcase
      end
      run_program("random");
   endtask

   initial begin
      i_rst  = 1'b1;
      errors = 0;
      checks = 0;
      clear_prog();
      void'($urandom(32'hb9abdec4));
      fork
         watch_trace();
      join_none
      @(posedge gwe);
      test_reset();
      test_bypass();
      test_logic();
      test_nzp();
      test_branch();
      test_random();
      afails = lc4_pipe_inst.lc4_pipe_properties_inst.assert_fails;
      $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, afails);
      if (errors == 0 && afails == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- lc4_pkg.sv
`include "lc4_macros.svh"

package lc4_pkg;

   typedef logic [`LC4_XLEN-1:0] word_t;
   typedef logic [$clog2(`LC4_NREGS)-1:0] reg_idx_t;

   // Negative, zero, positive
   typedef logic [2:0] nzp_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS
   } alu_op_e;

   typedef struct packed {
      logic [3:0] opcode;
      reg_idx_t   rd;
      reg_idx_t   rs;
      logic [2:0] sub;
      reg_idx_t   rt;
   } insn_rr_t;

   // rd doubles as the branch mask; imm9[5] flags the imm5 forms
   typedef struct packed {
      logic [3:0] opcode;
      logic [2:0] rd;
      logic [8:0] imm9;
   } insn_imm_t;

   typedef union packed {
      insn_rr_t  rr;
      insn_imm_t ri;
   } insn_u;

   typedef struct packed {
      alu_op_e  alu_op;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;
      logic     rs_re;
      logic     rt_re;
      logic     rf_we;
      logic     nzp_we;
      logic     is_branch;
      nzp_t     nzp_mask;
      logic     use_imm;
      word_t    imm;
      word_t    pc;
      word_t    pc_plus_one;
      word_t    insn;
      logic     valid;
   } ctrl_t;

   typedef struct packed {
      ctrl_t ctrl;
      word_t result;
   } xw_t;

   typedef struct packed {
      logic     valid;
      word_t    pc;
      word_t    insn;
      logic     rf_we;
      reg_idx_t rf_wsel;
      word_t    rf_data;
      logic     nzp_we;
      nzp_t     nzp_bits;
   } trace_t;

   // Condition code of a written value
   function automatic nzp_t nzp_of(word_t w);
      if (w == '0) begin
         return 3'b010;
      end
      return w[`LC4_XLEN-1] ? 3'b100 : 3'b001;
   endfunction

endpackage

//--- lc4_regfile.sv
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_regfile import lc4_pkg::*; (
   input  logic     gwe,
   input  logic     i_rst,
   input  reg_idx_t i_rs_sel,
   input  reg_idx_t i_rt_sel,
   output word_t    o_rs_data,
   output word_t    o_rt_data,
   input  reg_idx_t i_wsel,
   input  word_t    i_wdata,
   input  logic     i_we
);

   word_t regs [`LC4_NREGS];

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         for (int i = 0; i < `LC4_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (i_we) begin
         regs[i_wsel] <= i_wdata;
      end
   end

   // Decode sees the value retiring this cycle
   assign o_rs_data = (i_we && (i_wsel == i_rs_sel)) ? i_wdata : regs[i_rs_sel];
   assign o_rt_data = (i_we && (i_wsel == i_rt_sel)) ? i_wdata : regs[i_rt_sel];

endmodule

//--- lc4_result.sv
`timescale 1ns/1ps

module lc4_result import lc4_pkg::*; (
   input  logic     gwe,
   input  logic     i_rst,
   input  xw_t      i_xw,
   output reg_idx_t o_wsel,
   output word_t    o_wdata,
   output logic     o_we,
   output trace_t   o_wb,
   output trace_t   o_trace
);

   ctrl_t  ctrl_q;
   word_t  result_q;
   trace_t trace;

   always_ff @(posedge gwe) begin
      if (i_rst) begin
         ctrl_q <= '0;
      end else begin
         ctrl_q <= i_xw.ctrl;
      end
   end

   always_ff @(posedge gwe) begin
      result_q <= i_xw.result;
   end

   always_comb begin
      trace.valid    = ctrl_q.valid;
      trace.pc       = ctrl_q.pc;
      trace.insn     = ctrl_q.insn;
      trace.rf_we    = ctrl_q.valid && ctrl_q.rf_we;
      trace.rf_wsel  = ctrl_q.rd;
      trace.rf_data  = result_q;
      trace.nzp_we   = ctrl_q.valid && ctrl_q.nzp_we;
      trace.nzp_bits = nzp_of(result_q);
   end

   // Register file write port
   assign o_wsel  = trace.rf_wsel;
   assign o_wdata = trace.rf_data;
   assign o_we    = trace.rf_we;

   assign o_wb    = trace;
   assign o_trace = trace;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the LC4 pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module lc4_pipe_tb \
   -f lc4_pipe.f -o lc4_pipe_sim

./obj_dir/lc4_pipe_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
   exit 1
fi
exit 0
